//--- alu_unit.f
source/alu_pkg.sv
source/alu_decoder.sv
source/alu_op_queue.sv
source/core_alu.sv
source/alu_exec.sv
source/alu_unit.sv
verif/alu_unit_sva.sv
verif/alu_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module alu_unit_tb -f alu_unit.f -o alu_unit_sim \
  && ./obj_dir/alu_unit_sim 2>&1 | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null \
  && echo "run_sim: pass" \
  || { echo "run_sim: fail"; exit 1; }

//--- verif/alu_unit_tb.sv
`timescale 1ns/100ps

module alu_unit_tb;

  localparam int queue_depth = 4;
  localparam int wait_limit  = 20;
  localparam int table_len   = 29;

  // row is {opcode, operand, flags_en, expected acc, expected flags nvzc}
  localparam logic [24:0] op_table [table_len] = '{
    {alu_pkg::op_lda, 8'h80, 1'b1, 8'h80, 4'b1000},
    {alu_pkg::op_lda, 8'h00, 1'b1, 8'h00, 4'b0010},
    {alu_pkg::op_lda, 8'hf0, 1'b1, 8'hf0, 4'b1000},
    {alu_pkg::op_and, 8'h3c, 1'b1, 8'h30, 4'b0000},
    {alu_pkg::op_ora, 8'h8c, 1'b1, 8'hbc, 4'b1000},
    {alu_pkg::op_eor, 8'hbc, 1'b1, 8'h00, 4'b0010},
    {alu_pkg::op_lda, 8'h0f, 1'b1, 8'h0f, 4'b0000},
    {alu_pkg::op_bit, 8'hc0, 1'b1, 8'h0f, 4'b1110},
    {alu_pkg::op_bit, 8'h4f, 1'b1, 8'h0f, 4'b0100},
    {alu_pkg::op_bit, 8'h81, 1'b1, 8'h0f, 4'b1000},
    {alu_pkg::op_sec, 8'h00, 1'b1, 8'h0f, 4'b1001},
    {alu_pkg::op_lda, 8'h81, 1'b1, 8'h81, 4'b1001},
    {alu_pkg::op_asl, 8'h00, 1'b1, 8'h02, 4'b0001}, // zero in despite c set
    {alu_pkg::op_lsr, 8'h00, 1'b1, 8'h01, 4'b0000},
    {alu_pkg::op_lsr, 8'h00, 1'b1, 8'h00, 4'b0011},
    {alu_pkg::op_ror, 8'h00, 1'b1, 8'h80, 4'b1000},
    {alu_pkg::op_rol, 8'h00, 1'b1, 8'h00, 4'b0011},
    {alu_pkg::op_rol, 8'h00, 1'b1, 8'h01, 4'b0000},
    {alu_pkg::op_clc, 8'h00, 1'b1, 8'h01, 4'b0000},
    {alu_pkg::op_sec, 8'h00, 1'b1, 8'h01, 4'b0001},
    {alu_pkg::op_lda, 8'h80, 1'b0, 8'h80, 4'b0001}, // flags frozen from here
    {alu_pkg::op_asl, 8'h00, 1'b0, 8'h00, 4'b0001},
    {alu_pkg::op_adc, 8'h7f, 1'b0, 8'h80, 4'b0001},
    {alu_pkg::op_clc, 8'h00, 1'b0, 8'h80, 4'b0001},
    {alu_pkg::op_eor, 8'h80, 1'b0, 8'h00, 4'b0001},
    {alu_pkg::op_lda, 8'h40, 1'b1, 8'h40, 4'b0001},
    {alu_pkg::op_cmp, 8'h40, 1'b1, 8'h40, 4'b0011},
    {alu_pkg::op_cmp, 8'h41, 1'b1, 8'h40, 4'b1000},
    {alu_pkg::op_cmp, 8'h10, 1'b1, 8'h40, 4'b0001}
  };

  localparam alu_pkg::opcode_t burst_ops [4] = '{
    alu_pkg::op_lda, alu_pkg::op_adc, alu_pkg::op_eor, alu_pkg::op_sbc
  };

  logic             clk;
  logic             rst;
  logic             op_valid;
  alu_pkg::opcode_t opcode;
  logic [7:0]       operand;
  logic             flags_en;
  logic             stall;
  logic             busy;
  logic             result_valid;
  logic [7:0]       acc;
  logic [3:0]       flags;
  logic [31:0]      lfsr_state;
  logic [7:0]       model_acc;
  logic [3:0]       model_flags;

  alu_unit #(
    .queue_depth (queue_depth)
  ) i_alu_unit (
    .clk          (clk),
    .rst          (rst),
    .op_valid     (op_valid),
    .opcode       (opcode),
    .operand      (operand),
    .flags_en     (flags_en),
    .stall        (stall),
    .busy         (busy),
    .result_valid (result_valid),
    .acc          (acc),
    .flags        (flags)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s at %0t", msg, $time);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_values(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
      abort_run("first error reached");
    end
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // galois, x^32+x^22+x^2+x+1
  endfunction

  task automatic random_bits(input int count, output logic [7:0] bits);
    bits = 8'h00;
    for (int i = 0; i < count; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      bits = {bits[6:0], lfsr_state[0]};
    end
  endtask

  // returns {acc, n, v, z, c} after one operation
  function automatic logic [11:0] model_step(input alu_pkg::opcode_t op, input logic [7:0] opnd,
                                             input logic fe, input logic [7:0] a,
                                             input logic [3:0] f);
    logic [8:0] sum;
    logic [7:0] r;
    logic       n;
    logic       v;
    logic       z;
    logic       c;

    {n, v, z, c} = f;
    r   = a;
    sum = 9'h000;
    case (op)
      alu_pkg::op_lda: r = opnd;
      alu_pkg::op_adc:
      begin
        sum = {1'b0, a} + {1'b0, opnd} + {8'h00, f[0]};
        r = sum[7:0];
        c = sum[8];
        v = (a[7] == opnd[7]) && (r[7] != a[7]);
      end
      alu_pkg::op_sbc:
      begin
        sum = {1'b0, a} + {1'b0, ~opnd} + {8'h00, f[0]};
        r = sum[7:0];
        c = sum[8]; // no borrow
        v = (a[7] != opnd[7]) && (r[7] != a[7]);
      end
      alu_pkg::op_cmp:
      begin
        sum = {1'b0, a} + {1'b0, ~opnd} + 9'h001;
        c = sum[8];
      end
      alu_pkg::op_and: r = a & opnd;
      alu_pkg::op_ora: r = a | opnd;
      alu_pkg::op_eor: r = a ^ opnd;
      alu_pkg::op_asl:
      begin
        c = a[7];
        r = {a[6:0], 1'b0};
      end
      alu_pkg::op_lsr:
      begin
        c = a[0];
        r = {1'b0, a[7:1]};
      end
      alu_pkg::op_rol:
      begin
        c = a[7];
        r = {a[6:0], f[0]};
      end
      alu_pkg::op_ror:
      begin
        c = a[0];
        r = {f[0], a[7:1]};
      end
      alu_pkg::op_bit:
      begin
        n = opnd[7];
        v = opnd[6];
        z = ((a & opnd) == 8'h00);
      end
      alu_pkg::op_clc: c = 1'b0;
      alu_pkg::op_sec: c = 1'b1;
      default: ;
    endcase
    if (op == alu_pkg::op_cmp)
    begin
      n = sum[7];
      z = (sum[7:0] == 8'h00);
    end
    else if (op != alu_pkg::op_bit && op != alu_pkg::op_clc && op != alu_pkg::op_sec)
    begin
      n = r[7];
      z = (r == 8'h00);
    end
    if (!fe)
      {n, v, z, c} = f;
    return {r, n, v, z, c};
  endfunction

  task automatic wait_result(output int cycles);
    cycles = 0;
    while (!result_valid && cycles < wait_limit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!result_valid)
      abort_run("timed out waiting for result_valid");
  endtask

  task automatic wait_busy(input logic level);
    int cycles;
    cycles = 0;
    while (busy !== level && cycles < wait_limit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (busy !== level)
      abort_run(level ? "timed out waiting for busy to rise" : "timed out waiting for busy to fall");
  endtask

  task automatic execute_and_check(input alu_pkg::opcode_t op, input logic [7:0] opnd,
                                   input logic fe, input logic [7:0] exp_acc,
                                   input logic [3:0] exp_flags);
    int cycles;
    @(negedge clk);
    op_valid = 1'b1;
    opcode   = op;
    operand  = opnd;
    flags_en = fe;
    @(negedge clk);
    op_valid = 1'b0;
    wait_result(cycles);
    compare_values({op.name(), " latency"}, 32'(cycles + 1), 32'd3); // strobe to result
    compare_values({op.name(), " acc"}, 32'(acc), 32'(exp_acc));
    compare_values({op.name(), " flags"}, 32'(flags), 32'(exp_flags));
    model_acc   = exp_acc;
    model_flags = exp_flags;
  endtask

  task automatic check_against_model(input alu_pkg::opcode_t op, input logic [7:0] opnd,
                                     input logic fe);
    logic [11:0] pred;
    pred = model_step(op, opnd, fe, model_acc, model_flags);
    execute_and_check(op, opnd, fe, pred[11:4], pred[3:0]);
  endtask

  initial
  begin
    logic [24:0] row;
    logic [7:0]  pick;
    logic [11:0] pred;
    logic [11:0] expected_q [$];
    int          cycles;
    int          seen;

    rst         = 1'b1;
    op_valid    = 1'b0;
    opcode      = alu_pkg::op_lda;
    operand     = 8'h00;
    flags_en    = 1'b0;
    stall       = 1'b0;
    lfsr_state  = 32'd67378;
    model_acc   = 8'h00;
    model_flags = 4'h0;

    repeat (2) @(negedge clk);
    compare_values("acc after reset", 32'(acc), 32'd0);
    compare_values("flags after reset", 32'(flags), 32'd0);
    compare_values("result_valid after reset", 32'(result_valid), 32'd0);
    compare_values("busy after reset", 32'(busy), 32'd0);
    rst = 1'b0;

    for (int i = 0; i < table_len; i++)
    begin
      row = op_table[i[4:0]];
      execute_and_check(alu_pkg::opcode_t'(row[24:21]), row[20:13], row[12], row[11:4], row[3:0]);
    end

    for (int i = 0; i < 32; i++)
    begin
      random_bits(1, pick);
      check_against_model(pick[0] ? alu_pkg::op_sec : alu_pkg::op_clc, 8'h00, 1'b1);
      random_bits(8, pick);
      check_against_model(i[0] ? alu_pkg::op_sbc : alu_pkg::op_adc, pick, 1'b1);
      random_bits(8, pick);
      check_against_model(alu_pkg::op_cmp, pick, 1'b1);
    end

    // fill the queue while the executor is held
    @(negedge clk);
    stall = 1'b1;
    for (int k = 0; k < queue_depth; k++)
    begin
      random_bits(8, pick);
      pred = model_step(burst_ops[k[1:0]], pick, 1'b1, model_acc, model_flags);
      expected_q.push_back(pred);
      model_acc   = pred[11:4];
      model_flags = pred[3:0];
      op_valid    = 1'b1;
      opcode      = burst_ops[k[1:0]];
      operand     = pick;
      flags_en    = 1'b1;
      @(negedge clk);
    end
    op_valid = 1'b0;
    wait_busy(1'b1);
    compare_values("result_valid under stall", 32'(result_valid), 32'd0);
    stall = 1'b0;
    wait_busy(1'b0);

    seen = 0;
    while (expected_q.size() > 0)
    begin
      wait_result(cycles);
      if (seen > 0)
        compare_values("gap between queued results", 32'(cycles), 32'd0);
      pred = expected_q.pop_front();
      compare_values("queued acc", 32'(acc), 32'(pred[11:4]));
      compare_values("queued flags", 32'(flags), 32'(pred[3:0]));
      seen++;
      @(negedge clk);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- verif/alu_unit_sva.sv
`timescale 1ns/100ps

module alu_unit_sva (
  input logic clk,
  input logic rst,
  input logic push,
  input logic full,
  input logic pop,
  input logic empty,
  input logic result_valid
);

  logic [7:0] pending; // accepted ops whose result is not reported yet

  always_ff @(posedge clk)
  begin
    if (rst)
      pending <= '0;
    else
      pending <= pending + 8'(push && !full) - 8'(result_valid);
  end

  push_not_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("queue push while full");

  // nothing outstanding besides the result on the bus
  pop_not_empty: assert property (@(posedge clk) disable iff (rst)
    (pending == 8'(result_valid)) |-> (empty && !pop))
    else $error("queue entry or pop with nothing pushed");

  // back-to-back results need two ops in flight
  result_per_pop: assert property (@(posedge clk) disable iff (rst)
    result_valid && $past(result_valid) |-> $past(pending) >= 8'd2)
    else $error("result_valid held without two pops");

endmodule

bind alu_unit alu_unit_sva i_alu_unit_sva (
  .clk          (clk),
  .rst          (rst),
  .push         (push),
  .full         (busy),
  .pop          (pop),
  .empty        (empty),
  .result_valid (result_valid)
);

//--- source/alu_unit.sv
`timescale 1ns/100ps

module alu_unit #(
  parameter int queue_depth = 4
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           op_valid,
  input  alu_pkg::opcode_t               opcode,
  input  logic [alu_pkg::data_width-1:0] operand,
  input  logic                           flags_en,
  input  logic                           stall,
  output logic                           busy,
  output logic                           result_valid,
  output logic [alu_pkg::data_width-1:0] acc,
  output logic [3:0]                     flags
);

  logic                           push;
  alu_pkg::ctrl_t                 push_ctrl;
  logic [alu_pkg::data_width-1:0] push_operand;
  logic                           push_flags_en;
  logic                           pop;
  alu_pkg::ctrl_t                 head_ctrl;
  logic [alu_pkg::data_width-1:0] head_operand;
  logic                           head_flags_en;
  logic                           empty;

  alu_decoder i_alu_decoder (
    .clk           (clk),
    .rst           (rst),
    .op_valid      (op_valid),
    .opcode        (opcode),
    .operand       (operand),
    .flags_en      (flags_en),
    .push          (push),
    .push_ctrl     (push_ctrl),
    .push_operand  (push_operand),
    .push_flags_en (push_flags_en)
  );

  alu_op_queue #(
    .queue_depth (queue_depth)
  ) i_alu_op_queue (
    .clk           (clk),
    .rst           (rst),
    .push          (push),
    .push_ctrl     (push_ctrl),
    .push_operand  (push_operand),
    .push_flags_en (push_flags_en),
    .pop           (pop),
    .head_ctrl     (head_ctrl),
    .head_operand  (head_operand),
    .head_flags_en (head_flags_en),
    .empty         (empty),
    .full          (busy)        // full queue is the only back-pressure
  );

  alu_exec i_alu_exec (
    .clk           (clk),
    .rst           (rst),
    .stall         (stall),
    .empty         (empty),
    .head_ctrl     (head_ctrl),
    .head_operand  (head_operand),
    .head_flags_en (head_flags_en),
    .pop           (pop),
    .result_valid  (result_valid),
    .acc           (acc),
    .flags         (flags)
  );

endmodule

//--- source/alu_exec.sv
`timescale 1ns/100ps

module alu_exec (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           stall,
  input  logic                           empty,
  input  alu_pkg::ctrl_t                 head_ctrl,
  input  logic [alu_pkg::data_width-1:0] head_operand,
  input  logic                           head_flags_en,
  output logic                           pop,
  output logic                           result_valid,
  output logic [alu_pkg::data_width-1:0] acc,
  output logic [3:0]                     flags
);

  logic [alu_pkg::data_width-1:0] result;
  logic                           carry_next;
  logic                           overflow_next;
  logic                           sign_next;
  logic                           zero_next;

  assign pop = !empty && !stall;

  // flags is {n, v, z, c}
  core_alu i_core_alu (
    .control      (head_ctrl),
    .mask_p       (head_flags_en),
    .lhs          (acc),
    .rhs          (head_operand),
    .carry        (flags[0]),
    .overflow     (flags[2]),
    .sign         (flags[3]),
    .zero         (flags[1]),
    .result       (result),
    .carry_out    (carry_next),
    .overflow_out (overflow_next),
    .sign_out     (sign_next),
    .zero_out     (zero_next)
  );

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      acc          <= '0;
      flags        <= '0;
      result_valid <= 1'b0;
    end
    else
    begin
      result_valid <= pop;
      if (pop)
      begin
        if (head_ctrl[alu_pkg::ctl_write_acc])
          acc <= result;
        flags <= {sign_next, overflow_next, zero_next, carry_next};
      end
    end
  end

endmodule

//--- source/core_alu.sv
`timescale 1ns/100ps

module core_alu (
  input  alu_pkg::ctrl_t                 control,
  input  logic                           mask_p,
  input  logic [alu_pkg::data_width-1:0] lhs,
  input  logic [alu_pkg::data_width-1:0] rhs,
  input  logic                           carry,
  input  logic                           overflow,
  input  logic                           sign,
  input  logic                           zero,
  output logic [alu_pkg::data_width-1:0] result,
  output logic                           carry_out,
  output logic                           overflow_out,
  output logic                           sign_out,
  output logic                           zero_out
);

  localparam int dw = alu_pkg::data_width;

  logic [dw:0] rhs_ext; // extra bit carries the inversion into the sum
  logic        cin;
  logic        chain;

  always_comb
  begin
    rhs_ext = {1'b0, rhs};
    if (control[alu_pkg::ctl_clear_rhs])
      rhs_ext = '0;
    if (control[alu_pkg::ctl_invert_rhs])
      rhs_ext = ~rhs_ext;

    cin = carry;
    if (control[alu_pkg::ctl_clear_carry])
      cin = 1'b0;
    if (control[alu_pkg::ctl_invert_carry_in])
      cin = ~cin;

    chain  = cin;
    result = lhs;
    if (control[alu_pkg::ctl_select_rhs])
      result = rhs_ext[dw-1:0];
    else if (control[alu_pkg::ctl_select_adc])
      {chain, result} = {1'b0, lhs} + rhs_ext + {{dw{1'b0}}, cin};
    else if (control[alu_pkg::ctl_select_and])
      result = lhs & rhs_ext[dw-1:0];
    else if (control[alu_pkg::ctl_select_or])
      result = lhs | rhs_ext[dw-1:0];
    else if (control[alu_pkg::ctl_select_xor])
      result = lhs ^ rhs_ext[dw-1:0];
    else if (control[alu_pkg::ctl_select_rol])
      {chain, result} = {lhs, cin}; // msb out to carry
    else if (control[alu_pkg::ctl_select_ror])
      {result, chain} = {cin, lhs}; // lsb out to carry

    overflow_out = overflow;
    sign_out     = sign;
    carry_out    = carry;
    zero_out     = zero;

    if (mask_p)
    begin
      if (control[alu_pkg::ctl_flags_rhs])
      begin
        overflow_out = rhs[dw-2];
        sign_out     = rhs[dw-1];
      end
      else
      begin
        if (control[alu_pkg::ctl_adc_overflow])
          overflow_out = (lhs[dw-1] == rhs_ext[dw-1]) && (result[dw-1] != lhs[dw-1]);
        if (control[alu_pkg::ctl_result_sign])
          sign_out = result[dw-1];
      end

      if (control[alu_pkg::ctl_invert_carry_out])
        carry_out = ~chain;
      else if (control[alu_pkg::ctl_set_carry])
        carry_out = chain;

      if (control[alu_pkg::ctl_result_zero])
        zero_out = ~|result;
    end
  end

endmodule

//--- source/alu_op_queue.sv
`timescale 1ns/100ps

module alu_op_queue #(
  parameter int queue_depth = 4
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           push,
  input  alu_pkg::ctrl_t                 push_ctrl,
  input  logic [alu_pkg::data_width-1:0] push_operand,
  input  logic                           push_flags_en,
  input  logic                           pop,
  output alu_pkg::ctrl_t                 head_ctrl,
  output logic [alu_pkg::data_width-1:0] head_operand,
  output logic                           head_flags_en,
  output logic                           empty,
  output logic                           full
);

  localparam int ptr_w = $clog2(queue_depth);
  localparam int cnt_w = ptr_w + 1;

  logic [alu_pkg::op_width-1:0] mem [queue_depth];
  logic [ptr_w-1:0]             wr_ptr;
  logic [ptr_w-1:0]             rd_ptr;
  logic [cnt_w-1:0]             count;
  logic                         do_push;
  logic                         do_pop;

  assign empty   = (count == '0);
  assign full    = (count == cnt_w'(queue_depth));
  assign do_push = push && !full; // dropped when full
  assign do_pop  = pop && !empty;

  assign {head_ctrl, head_operand, head_flags_en} = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= {push_ctrl, push_operand, push_flags_en};
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + ptr_w'(1); // wraps, depth is a power of two
      if (do_pop)
        rd_ptr <= rd_ptr + ptr_w'(1);
      if (do_push && !do_pop)
        count <= count + cnt_w'(1);
      else if (do_pop && !do_push)
        count <= count - cnt_w'(1);
    end
  end

endmodule

//--- source/alu_decoder.sv
`timescale 1ns/100ps

module alu_decoder (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           op_valid,
  input  alu_pkg::opcode_t               opcode,
  input  logic [alu_pkg::data_width-1:0] operand,
  input  logic                           flags_en,
  output logic                           push,
  output alu_pkg::ctrl_t                 push_ctrl,
  output logic [alu_pkg::data_width-1:0] push_operand,
  output logic                           push_flags_en
);

  alu_pkg::ctrl_t ctrl_next;

  always_comb
  begin
    ctrl_next = '0;
    case (opcode)
      alu_pkg::op_lda:
        ctrl_next[alu_pkg::ctl_select_rhs] = 1'b1;
      alu_pkg::op_adc, alu_pkg::op_sbc, alu_pkg::op_cmp:
      begin
        ctrl_next[alu_pkg::ctl_select_adc] = 1'b1;
        ctrl_next[alu_pkg::ctl_set_carry]  = 1'b1;
        if (opcode != alu_pkg::op_cmp)
          ctrl_next[alu_pkg::ctl_adc_overflow] = 1'b1;
        if (opcode != alu_pkg::op_adc)
        begin
          ctrl_next[alu_pkg::ctl_invert_rhs]       = 1'b1;
          ctrl_next[alu_pkg::ctl_invert_carry_out] = 1'b1; // carry = not borrow
        end
        if (opcode == alu_pkg::op_cmp)
        begin
          ctrl_next[alu_pkg::ctl_clear_carry]     = 1'b1; // forced carry-in of 1
          ctrl_next[alu_pkg::ctl_invert_carry_in] = 1'b1;
        end
      end
      alu_pkg::op_and, alu_pkg::op_bit:
        ctrl_next[alu_pkg::ctl_select_and] = 1'b1;
      alu_pkg::op_ora:
        ctrl_next[alu_pkg::ctl_select_or] = 1'b1;
      alu_pkg::op_eor:
        ctrl_next[alu_pkg::ctl_select_xor] = 1'b1;
      alu_pkg::op_asl, alu_pkg::op_rol:
      begin
        ctrl_next[alu_pkg::ctl_select_rol]  = 1'b1;
        ctrl_next[alu_pkg::ctl_set_carry]   = 1'b1;
        ctrl_next[alu_pkg::ctl_clear_carry] = (opcode == alu_pkg::op_asl);
      end
      alu_pkg::op_lsr, alu_pkg::op_ror:
      begin
        ctrl_next[alu_pkg::ctl_select_ror]  = 1'b1;
        ctrl_next[alu_pkg::ctl_set_carry]   = 1'b1;
        ctrl_next[alu_pkg::ctl_clear_carry] = (opcode == alu_pkg::op_lsr);
      end
      alu_pkg::op_clc, alu_pkg::op_sec:
      begin
        ctrl_next[alu_pkg::ctl_clear_carry]     = 1'b1; // result stays lhs
        ctrl_next[alu_pkg::ctl_invert_carry_in] = (opcode == alu_pkg::op_sec);
        ctrl_next[alu_pkg::ctl_set_carry]       = 1'b1;
      end
      default:
        ctrl_next = '0; // unused codes leave acc and flags alone
    endcase

    // n and z follow the result for everything that writes acc, plus cmp
    if (opcode <= alu_pkg::op_cmp)
    begin
      ctrl_next[alu_pkg::ctl_result_sign] = 1'b1;
      ctrl_next[alu_pkg::ctl_result_zero] = 1'b1;
      ctrl_next[alu_pkg::ctl_write_acc]   = (opcode != alu_pkg::op_cmp);
    end
    if (opcode == alu_pkg::op_bit)
    begin
      ctrl_next[alu_pkg::ctl_flags_rhs]   = 1'b1; // n, v from operand
      ctrl_next[alu_pkg::ctl_result_zero] = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      push <= 1'b0;
    else
      push <= op_valid;
  end

  always_ff @(posedge clk)
  begin
    if (op_valid)
    begin
      push_ctrl     <= ctrl_next;
      push_operand  <= operand;
      push_flags_en <= flags_en;
    end
  end

endmodule

//--- source/alu_pkg.sv
package alu_pkg;

  localparam int data_width = 8;

  // one bit per control index below
  localparam int ctrl_width = 18;

  typedef logic [ctrl_width-1:0] ctrl_t;

  // operand conditioning
  localparam int ctl_clear_rhs        = 0;
  localparam int ctl_invert_rhs       = 1;
  localparam int ctl_clear_carry      = 2;
  localparam int ctl_invert_carry_in  = 3;

  // result select, lowest index wins
  localparam int ctl_select_rhs       = 4;
  localparam int ctl_select_adc       = 5;
  localparam int ctl_select_and       = 6;
  localparam int ctl_select_or        = 7;
  localparam int ctl_select_xor       = 8;
  localparam int ctl_select_rol       = 9;
  localparam int ctl_select_ror       = 10;

  // flag update
  localparam int ctl_flags_rhs        = 11;
  localparam int ctl_adc_overflow     = 12;
  localparam int ctl_result_sign      = 13;
  localparam int ctl_set_carry        = 14;
  localparam int ctl_invert_carry_out = 15;
  localparam int ctl_result_zero      = 16;

  localparam int ctl_write_acc        = 17;

  typedef enum logic [3:0] {
    op_lda = 4'h0,
    op_adc = 4'h1,
    op_sbc = 4'h2,
    op_and = 4'h3,
    op_ora = 4'h4,
    op_eor = 4'h5,
    op_asl = 4'h6,
    op_lsr = 4'h7,
    op_rol = 4'h8,
    op_ror = 4'h9,
    op_cmp = 4'ha,
    op_bit = 4'hb,
    op_clc = 4'hc,
    op_sec = 4'hd
  } opcode_t;

  // queued entry is {ctrl, operand, flags_en}
  localparam int op_width = ctrl_width + data_width + 1;

endpackage
